/* hw/panel_pkg.sv */
`default_nettype none

package panel_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // accumulator and operand width
  localparam int ACC_W = 8;

  // board pin widths
  localparam int SW_W  = 11;
  localparam int BTN_W = 5;

  // all segments off, active low
  localparam logic [6:0] SEG_BLANK = 7'b111_1111;

  ////////////////////////////////////////
  // key positions on btn
  ////////////////////////////////////////

  localparam int KEY_ADD  = 0;
  localparam int KEY_CLR  = 1;
  localparam int KEY_MODE = 4;

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  // panel mode, shown on led[8]
  typedef enum logic [0:0] {
    LOCKED = 1'b0,
    EDIT   = 1'b1
  } panel_state_t;

  // accumulator operation, qualified by op_valid
  typedef enum logic [0:0] {
    ACC_ADD   = 1'b0,
    ACC_CLEAR = 1'b1
  } acc_op_t;

endpackage

`default_nettype wire

/* hw/sample_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_timer #(
  parameter int DIV_FAST = 50000,
  parameter int DIV_SLOW = 500000
) (
  input  wire  clk_50m,
  input  wire  rst_n,
  input  logic slow_sel,
  output logic sample_tick
);

  // counter sized for the longer of the two periods
  localparam int DIV_MAX = (DIV_SLOW > DIV_FAST) ? DIV_SLOW : DIV_FAST;
  localparam int CNT_W   = $clog2(DIV_MAX + 1);

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] reload_val;
  logic             slow_sel_q;
  logic             rate_change;

  // period minus one, since zero is a counted state
  assign reload_val = slow_sel ? CNT_W'(DIV_SLOW - 1) : CNT_W'(DIV_FAST - 1);

  // window switch seen this cycle
  assign rate_change = (slow_sel != slow_sel_q);

  ////////////////////////////////////////
  // down-counter
  ////////////////////////////////////////

  always_ff @(posedge clk_50m or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q       <= CNT_W'(DIV_FAST - 1);
      slow_sel_q  <= 1'b0;
      sample_tick <= 1'b0;
    end else begin
      slow_sel_q <= slow_sel;
      if (rate_change) begin
        // restart at the new rate, no tick
        cnt_q       <= reload_val;
        sample_tick <= 1'b0;
      end else if (cnt_q == '0) begin
        cnt_q       <= reload_val;
        sample_tick <= 1'b1;
      end else begin
        cnt_q       <= cnt_q - 1'b1;
        sample_tick <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/input_sampler.sv */
`timescale 1ns/1ps
`default_nettype none

module input_sampler #(
  parameter type      payload_t    = logic,
  parameter payload_t RESET_VALUE  = '0,
  parameter int       STABLE_TICKS = 3
) (
  input  wire      clk_50m,
  input  wire      rst_n,
  input  logic     sample_tick,
  input  payload_t raw,
  output payload_t clean
);

  // enough bits to hold STABLE_TICKS
  localparam int CNT_W = $clog2(STABLE_TICKS + 1);

  payload_t         sync_q1;
  payload_t         sync_q2;
  payload_t         cand_q;
  logic [CNT_W-1:0] cnt_q;
  logic             same;
  logic             cnt_full;

  ////////////////////////////////////////
  // two-flop synchronizer
  ////////////////////////////////////////

  // reset to the idle level so no false edge follows reset
  always_ff @(posedge clk_50m or negedge rst_n) begin
    if (!rst_n) begin
      sync_q1 <= RESET_VALUE;
      sync_q2 <= RESET_VALUE;
    end else begin
      sync_q1 <= raw;
      sync_q2 <= sync_q1;
    end
  end

  ////////////////////////////////////////
  // stability filter
  ////////////////////////////////////////

  // sample matches the value under test
  assign same = (sync_q2 == cand_q);

  // counter saturates once the value is accepted
  assign cnt_full = (cnt_q == CNT_W'(STABLE_TICKS));

  always_ff @(posedge clk_50m or negedge rst_n) begin
    if (!rst_n) begin
      cand_q <= RESET_VALUE;
      cnt_q  <= CNT_W'(STABLE_TICKS);
      clean  <= RESET_VALUE;
    end else if (sample_tick) begin
      if (!same) begin
        // new value, start counting again
        cand_q <= sync_q2;
        cnt_q  <= '0;
      end else if (!cnt_full) begin
        cnt_q <= cnt_q + 1'b1;
        // last matching sample, pass it on
        if (cnt_q == CNT_W'(STABLE_TICKS - 1)) begin
          clean <= cand_q;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/panel_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module panel_ctrl (
  input  wire                          clk_50m,
  input  wire                          rst_n,
  input  logic [panel_pkg::BTN_W-1:0]  btn_db,
  output logic                         op_valid,
  output panel_pkg::acc_op_t           op,
  output logic                         edit
);

  logic [panel_pkg::BTN_W-1:0] btn_q;
  logic [panel_pkg::BTN_W-1:0] fall;
  logic                        fall_add;
  logic                        fall_clr;
  logic                        fall_mode;
  panel_pkg::panel_state_t     state_q;

  ////////////////////////////////////////
  // key edge detect
  ////////////////////////////////////////

  // keys are active low, a press is 1 -> 0
  always_ff @(posedge clk_50m or negedge rst_n) begin
    if (!rst_n) begin
      btn_q <= '1;
    end else begin
      btn_q <= btn_db;
    end
  end

  assign fall = btn_q & ~btn_db;

  // only three keys matter
  assign fall_add  = fall[panel_pkg::KEY_ADD];
  assign fall_clr  = fall[panel_pkg::KEY_CLR];
  assign fall_mode = fall[panel_pkg::KEY_MODE];

  ////////////////////////////////////////
  // mode FSM
  ////////////////////////////////////////

  // mode key flips LOCKED <-> EDIT
  always_ff @(posedge clk_50m or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= panel_pkg::LOCKED;
    end else if (fall_mode) begin
      if (state_q == panel_pkg::EDIT) begin
        state_q <= panel_pkg::LOCKED;
      end else begin
        state_q <= panel_pkg::EDIT;
      end
    end
  end

  assign edit = (state_q == panel_pkg::EDIT);

  ////////////////////////////////////////
  // operation issue
  ////////////////////////////////////////

  // one-cycle strobe in the cycle the edge is seen
  // mode key takes the cycle, nothing issued in LOCKED
  assign op_valid = edit && !fall_mode && (fall_add || fall_clr);

  // add beats clear on a tie
  assign op = fall_add ? panel_pkg::ACC_ADD : panel_pkg::ACC_CLEAR;

endmodule

`default_nettype wire

/* hw/acc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module acc_unit (
  input  wire                          clk_50m,
  input  wire                          rst_n,
  input  logic                         op_valid,
  input  panel_pkg::acc_op_t           op,
  input  logic [panel_pkg::ACC_W-1:0]  operand,
  output logic [panel_pkg::ACC_W-1:0]  acc,
  output logic                         carry
);

  // one extra bit catches the carry-out
  logic [panel_pkg::ACC_W:0] sum;

  assign sum = {1'b0, acc} + {1'b0, operand};

  ////////////////////////////////////////
  // accumulator and carry flag
  ////////////////////////////////////////

  // every op is taken in the cycle it arrives
  always_ff @(posedge clk_50m or negedge rst_n) begin
    if (!rst_n) begin
      acc   <= '0;
      carry <= 1'b0;
    end else if (op_valid) begin
      case (op)
        panel_pkg::ACC_ADD: begin
          // wraps modulo 2**ACC_W
          acc   <= sum[panel_pkg::ACC_W-1:0];
          // sticky until a clear
          carry <= carry | sum[panel_pkg::ACC_W];
        end
        panel_pkg::ACC_CLEAR: begin
          acc   <= '0;
          carry <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/seg7_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module seg7_decoder (
  input  logic [3:0] nibble,
  output logic [6:0] seg
);

  ////////////////////////////////////////
  // hex glyph table
  ////////////////////////////////////////

  // bit order gfedcba, a lit segment is 0
  always_comb begin
    case (nibble)
      4'h0:    seg = 7'b100_0000;
      // 1 on b and c
      4'h1:    seg = 7'b111_1001;
      4'h2:    seg = 7'b010_0100;
      4'h3:    seg = 7'b011_0000;
      4'h4:    seg = 7'b001_1001;
      4'h5:    seg = 7'b001_0010;
      4'h6:    seg = 7'b000_0010;
      4'h7:    seg = 7'b111_1000;
      4'h8:    seg = 7'b000_0000;
      4'h9:    seg = 7'b001_0000;
      4'hA:    seg = 7'b000_1000;
      // lowercase b so it differs from 8
      4'hB:    seg = 7'b000_0011;
      4'hC:    seg = 7'b100_0110;
      // lowercase d so it differs from 0
      4'hD:    seg = 7'b010_0001;
      4'hE:    seg = 7'b000_0110;
      4'hF:    seg = 7'b000_1110;
      // x or z on the input
      default: seg = panel_pkg::SEG_BLANK;
    endcase
  end

endmodule

`default_nettype wire

/* hw/mainframe.sv */
`timescale 1ns/1ps
`default_nettype none

module mainframe #(
  parameter int DIV_FAST     = 50000,
  parameter int DIV_SLOW     = 500000,
  parameter int STABLE_TICKS = 3
) (
  input  wire                         clk_50m,
  input  wire                         rst_n,
  input  logic [panel_pkg::SW_W-1:0]  sw,
  input  logic [panel_pkg::BTN_W-1:0] btn,
  output logic [9:0]                  led,
  output logic [6:0]                  hex0,
  output logic [6:0]                  hex1,
  output logic [7:0]                  hex_on
);

  logic                         sample_tick;
  logic [panel_pkg::SW_W-1:0]   sw_db;
  logic [panel_pkg::BTN_W-1:0]  btn_db;
  logic                         op_valid;
  panel_pkg::acc_op_t           op;
  logic                         edit;
  logic [panel_pkg::ACC_W-1:0]  acc;
  logic                         carry;

  ////////////////////////////////////////
  // input conditioning
  ////////////////////////////////////////

  // top switch picks the slow window
  sample_timer #(.DIV_FAST(DIV_FAST), .DIV_SLOW(DIV_SLOW)) u_sample_timer (
    .clk_50m     (clk_50m),
    .rst_n       (rst_n),
    .slow_sel    (sw_db[panel_pkg::SW_W-1]),
    .sample_tick (sample_tick)
  );

  input_sampler #(
    .payload_t    (logic [panel_pkg::SW_W-1:0]),
    .RESET_VALUE  ('0),
    .STABLE_TICKS (STABLE_TICKS)
  ) sw_sampler (
    .clk_50m     (clk_50m),
    .rst_n       (rst_n),
    .sample_tick (sample_tick),
    .raw         (sw),
    .clean       (sw_db)
  );

  // buttons idle high
  input_sampler #(
    .payload_t    (logic [panel_pkg::BTN_W-1:0]),
    .RESET_VALUE  ('1),
    .STABLE_TICKS (STABLE_TICKS)
  ) btn_sampler (
    .clk_50m     (clk_50m),
    .rst_n       (rst_n),
    .sample_tick (sample_tick),
    .raw         (btn),
    .clean       (btn_db)
  );

  ////////////////////////////////////////
  // control and datapath
  ////////////////////////////////////////

  panel_ctrl u_panel_ctrl (
    .clk_50m  (clk_50m),
    .rst_n    (rst_n),
    .btn_db   (btn_db),
    .op_valid (op_valid),
    .op       (op),
    .edit     (edit)
  );

  acc_unit u_acc_unit (
    .clk_50m  (clk_50m),
    .rst_n    (rst_n),
    .op_valid (op_valid),
    .op       (op),
    .operand  (sw_db[panel_pkg::ACC_W-1:0]),
    .acc      (acc),
    .carry    (carry)
  );

  ////////////////////////////////////////
  // display and pins
  ////////////////////////////////////////

  seg7_decoder u_seg_lo (.nibble(acc[3:0]), .seg(hex0));
  seg7_decoder u_seg_hi (.nibble(acc[7:4]), .seg(hex1));

  // digits 1:0 on, the other six off
  assign hex_on = 8'b1111_1100;

  // carry, mode, then switch echo
  assign led = {carry, edit, sw_db[7:0]};

endmodule

`default_nettype wire

/* sim/mainframe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mainframe_tb;

  // columns per step and limits
  localparam int COLS      = 6;
  localparam int MAX_STEPS = 64;
  localparam int HOLD_MAX  = 2000;
  localparam int RST_CYC   = 5;

  logic        clk_50m;
  logic        rst_n;
  logic [10:0] sw;
  logic [4:0]  btn;
  logic [9:0]  led;
  logic [6:0]  hex0;
  logic [6:0]  hex1;
  logic [7:0]  hex_on;

  logic [15:0] pat [0:COLS*MAX_STEPS-1];
  int          pass_cnt;
  int          fail_cnt;

  mainframe #(.DIV_FAST(4), .DIV_SLOW(16), .STABLE_TICKS(3)) uut (
    .clk_50m (clk_50m),
    .rst_n   (rst_n),
    .sw      (sw),
    .btn     (btn),
    .led     (led),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex_on  (hex_on)
  );

  // 10 ns period
  always #5 clk_50m = ~clk_50m;

  ////////////////////////////////////////
  // display readback
  ////////////////////////////////////////

  // gfedcba active low back to a nibble
  // bit 4 set when the glyph is known
  function automatic logic [4:0] glyph_value(input logic [6:0] seg);
    case (seg)
      7'h40:   return 5'h10;
      7'h79:   return 5'h11;
      7'h24:   return 5'h12;
      7'h30:   return 5'h13;
      7'h19:   return 5'h14;
      7'h12:   return 5'h15;
      7'h02:   return 5'h16;
      7'h78:   return 5'h17;
      7'h00:   return 5'h18;
      7'h10:   return 5'h19;
      7'h08:   return 5'h1a;
      // lowercase b
      7'h03:   return 5'h1b;
      7'h46:   return 5'h1c;
      // lowercase d
      7'h21:   return 5'h1d;
      7'h06:   return 5'h1e;
      7'h0e:   return 5'h1f;
      default: return 5'h00;
    endcase
  endfunction

  ////////////////////////////////////////
  // one pattern step
  ////////////////////////////////////////

  task automatic run_step(input int idx);
    logic [15:0] step_no;
    logic [15:0] sw_v;
    logic [15:0] btn_v;
    logic [15:0] hold;
    logic [15:0] exp_acc;
    logic [15:0] exp_led;
    logic [4:0]  lo;
    logic [4:0]  hi;
    logic [7:0]  got_acc;
    int          errs;
    int          n;
    step_no = pat[idx*COLS];
    sw_v    = pat[idx*COLS+1];
    btn_v   = pat[idx*COLS+2];
    hold    = pat[idx*COLS+3];
    exp_acc = pat[idx*COLS+4];
    exp_led = pat[idx*COLS+5];
    errs    = 0;
    // new inputs just after the edge
    @(posedge clk_50m);
    #1;
    sw  = sw_v[10:0];
    btn = btn_v[4:0];
    if (int'(hold) > HOLD_MAX) begin
      $display("step %0h: hold of %0d clocks is over the %0d clock limit, timeout",
               step_no, hold, HOLD_MAX);
      errs++;
    end else begin
      n = 0;
      while (n < int'(hold)) begin
        @(posedge clk_50m);
        n++;
      end
    end
    // outputs settled, away from the edge
    @(negedge clk_50m);
    lo = glyph_value(hex0);
    hi = glyph_value(hex1);
    if (!lo[4] || !hi[4]) begin
      $display("step %0h: unknown glyph on the display, hex1 %b hex0 %b",
               step_no, hex1, hex0);
      errs++;
    end else begin
      got_acc = {hi[3:0], lo[3:0]};
      if (got_acc !== exp_acc[7:0]) begin
        $display("MISMATCH %0t acc expected %02h actual %02h", $time, exp_acc[7:0], got_acc);
        errs++;
      end
    end
    if (led[9:8] !== exp_led[1:0]) begin
      $display("MISMATCH %0t led[9:8] expected %b actual %b", $time, exp_led[1:0], led[9:8]);
      errs++;
    end
    // switch echo
    if (led[7:0] !== sw_v[7:0]) begin
      $display("MISMATCH %0t led[7:0] expected %02h actual %02h", $time, sw_v[7:0], led[7:0]);
      errs++;
    end
    if (hex_on !== 8'hfc) begin
      $display("MISMATCH %0t hex_on expected fc actual %02h", $time, hex_on);
      errs++;
    end
    if (errs == 0) begin
      pass_cnt++;
      $display("step %0h ok", step_no);
    end else begin
      fail_cnt++;
      $display("step %0h failed, %0d errors", step_no, errs);
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin : main
    int idx;
    int n;
    clk_50m  = 1'b0;
    rst_n    = 1'b0;
    sw       = '0;
    btn      = '1;
    pass_cnt = 0;
    fail_cnt = 0;
    // ffff marks unused entries
    for (idx = 0; idx < COLS*MAX_STEPS; idx++) begin
      pat[idx] = 16'hffff;
    end
    $readmemh("sim/panel_patterns.txt", pat);
    n = 0;
    while (n < RST_CYC) begin
      @(posedge clk_50m);
      n++;
    end
    #1;
    rst_n = 1'b1;
    idx = 0;
    while (idx < MAX_STEPS && pat[idx*COLS] != 16'hffff) begin
      run_step(idx);
      idx++;
    end
    if (idx == 0) begin
      $display("no steps read from the pattern file");
      fail_cnt++;
    end
    $display("steps passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
hw/panel_pkg.sv
hw/sample_timer.sv
hw/input_sampler.sv
hw/panel_ctrl.sv
hw/acc_unit.sv
hw/seg7_decoder.sv
hw/mainframe.sv
sim/mainframe_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := mainframe_tb
RTL_TOP    := mainframe
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --top-module $(RTL_TOP)
SIM_FLAGS  := --binary --timing -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
BIN        := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

# build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

/* sim/panel_patterns.txt */
// step  sw   btn  hold  acc  led[9:8]   (all hex, btn active low, hold in clocks)
// 1f idle, 1e add key, 1d clear key, 0f mode key, 405 = slow window with sw 05
00  000  1f  80  00  0
01  007  1e  80  00  0
02  007  1f  80  00  0
03  007  1d  80  00  0
04  007  1f  80  00  0
05  007  0f  80  00  1
06  007  1f  80  00  1
07  007  1e  80  07  1
08  007  1f  80  07  1
09  007  1e  80  0e  1
0a  003  1f  80  0e  1
0b  003  1e  80  11  1
0c  0f0  1f  80  11  1
0d  0f0  1e  80  01  3
0e  005  1f  80  01  3
0f  005  1e  80  06  3
10  005  1f  80  06  3
11  005  1d  80  00  1
12  405  1f  80  00  1
13  405  1e  02  00  1
14  405  1f  80  00  1
15  405  1e  80  05  1
16  005  1f  80  05  1
17  005  1e  02  05  1
18  005  1f  80  05  1
19  005  1e  80  0a  1
1a  005  1f  80  0a  1
1b  005  0f  80  0a  0
1c  005  1f  80  0a  0
